/* compile.f */
design/vu_pkg.sv
design/vu_dispatcher.sv
design/vu_lane.sv
design/vu_masku.sv
design/vu_writeback.sv
design/vu_top.sv
verification/vu_chk.sv
verification/vu_tb.sv

/* Makefile */
# Verilator build and run for the vector slice

VERILATOR ?= verilator
TOP       ?= vu_tb
RTL_TOP   ?= vu_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --assert
LINTFLAGS ?=
PASS_MSG  ?= Everything OK

RTL_SRCS ?= design/vu_pkg.sv \
            design/vu_dispatcher.sv \
            design/vu_lane.sv \
            design/vu_masku.sv \
            design/vu_writeback.sv \
            design/vu_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

/* verification/vu_tb.sv */
// Directed testbench for the vector slice top level, run as the simulation top with the bound checker
module vu_tb import vu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESP_TIMEOUT = 20;

  logic    clk = 1'b0;
  logic    rst;
  logic    req_valid;
  alu_op_e req_op;
  cmp_op_e req_cmp;
  logic    req_scalar_en;
  vec_t    req_vs1;
  elem_t   req_scalar;
  vec_t    req_vs2;
  vec_t    req_vd_old;
  logic    resp_valid;
  vec_t    resp_vd;
  mask_t   resp_mask;
  popc_t   resp_popc;

  integer seed = 47691;
  int     cyc = 0;
  int     err_cnt = 0;
  int     chk_cnt = 0;
  int     test_cnt = 0;

  // Expected responses in request order
  vec_t  exp_vd_q[$];
  mask_t exp_mask_q[$];
  popc_t exp_popc_q[$];
  int    exp_cyc_q[$];

  vu_top u_vu_top (
    .clk_i          (clk          ),
    .rst_i          (rst          ),
    .req_valid_i    (req_valid    ),
    .req_op_i       (req_op       ),
    .req_cmp_i      (req_cmp      ),
    .req_scalar_en_i(req_scalar_en),
    .req_vs1_i      (req_vs1      ),
    .req_scalar_i   (req_scalar   ),
    .req_vs2_i      (req_vs2      ),
    .req_vd_old_i   (req_vd_old   ),
    .resp_valid_o   (resp_valid   ),
    .resp_vd_o      (resp_vd      ),
    .resp_mask_o    (resp_mask    ),
    .resp_popc_o    (resp_popc    )
  );

  always #10 clk = ~clk;

  // Free running edge count for latency checks
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Result is b op a with a as the first operand
  function automatic elem_t model_alu(alu_op_e op, elem_t a, elem_t b);
    int sa;
    int sb;
    sa = int'(a);
    sb = int'(b);
    case (op)
      ALU_ADD: return elem_t'(sb + sa);
      ALU_SUB: return elem_t'(sb - sa);
      ALU_AND: return b & a;
      ALU_XOR: return b ^ a;
      ALU_MIN: return (sb < sa) ? b : a;
      ALU_MAX: return (sb > sa) ? b : a;
      default: return 'x;
    endcase
  endfunction

  function automatic logic model_cmp(cmp_op_e cmp, elem_t a, elem_t b);
    int sa;
    int sb;
    sa = int'(a);
    sb = int'(b);
    case (cmp)
      CMP_EQ:  return sb == sa;
      CMP_NE:  return sb != sa;
      CMP_LT:  return sb < sa;
      default: return 1'b1;
    endcase
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < NR_LANES; i++) begin
      v[i] = elem_t'($random(seed));
    end
    return v;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_vec(input string name, input vec_t got, input vec_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_popc(input string name, input popc_t got, input popc_t exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_valid(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic send_req(input alu_op_e op, input cmp_op_e cmp, input logic scalar_en,
                          input vec_t vs1, input elem_t scalar, input vec_t vs2,
                          input vec_t vd_old);
    vec_t  src1;
    vec_t  vd_exp;
    mask_t mask_exp;
    popc_t popc_exp;
    popc_exp = '0;
    for (int i = 0; i < NR_LANES; i++) begin
      src1[i] = scalar_en ? scalar : vs1[i];
      mask_exp[i] = model_cmp(cmp, src1[i], vs2[i]);
      vd_exp[i] = mask_exp[i] ? model_alu(op, src1[i], vs2[i]) : vd_old[i];
      if (mask_exp[i]) begin
        popc_exp++;
      end
    end
    @(posedge clk);
    #2;
    req_valid     = 1'b1;
    req_op        = op;
    req_cmp       = cmp;
    req_scalar_en = scalar_en;
    req_vs1       = vs1;
    req_scalar    = scalar;
    req_vs2       = vs2;
    req_vd_old    = vd_old;
    exp_vd_q.push_back(vd_exp);
    exp_mask_q.push_back(mask_exp);
    exp_popc_q.push_back(popc_exp);
    // Sampled at the next edge, out of the writeback three edges from now
    exp_cyc_q.push_back(cyc + 3);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #2;
    req_valid     = 1'b0;
    req_scalar_en = 1'b0;
  endtask

  // Waits for n responses and then makes sure no extra one follows
  task automatic collect_resps(input string test, input int n);
    int waited;
    int exp_cyc;
    for (int r = 0; r < n; r++) begin
      waited = 0;
      @(negedge clk);
      while (resp_valid !== 1'b1) begin
        waited++;
        if (waited > RESP_TIMEOUT) begin
          $display("timeout in %s, response %0d did not arrive within %0d cycles",
                   test, r, RESP_TIMEOUT);
          $display("Something failed");
          $finish;
        end
        @(negedge clk);
      end
      exp_cyc = exp_cyc_q.pop_front();
      chk_cnt++;
      if (cyc != exp_cyc) begin
        $display("error at %0t ns: resp_valid_o cycle got %0d expected %0d",
                 $time, cyc, exp_cyc);
        err_cnt++;
      end
      check_vec("resp_vd_o", resp_vd, exp_vd_q.pop_front());
      check_mask("resp_mask_o", resp_mask, exp_mask_q.pop_front());
      check_popc("resp_popc_o", resp_popc, exp_popc_q.pop_front());
    end
    repeat (4) begin
      @(negedge clk);
      if (resp_valid !== 1'b0) begin
        $display("unexpected extra response in %s at %0t ns", test, $time);
        err_cnt++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    $display("test %s finished, %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic reset_behavior();
    int errs;
    errs = err_cnt;
    repeat (4) begin
      @(posedge clk);
      #2;
      check_valid("resp_valid_o", resp_valid, 1'b0);
    end
    rst = 1'b0;
    repeat (6) begin
      @(negedge clk);
      check_valid("resp_valid_o", resp_valid, 1'b0);
    end
    report_test("reset", errs);
  endtask

  task automatic alu_ops();
    int      errs;
    alu_op_e op;
    vec_t    edge1;
    vec_t    edge2;
    errs = err_cnt;
    // Wrap and sign corners
    edge1 = {16'h0001, 16'h8000, 16'h7fff, 16'hffff};
    edge2 = {16'h7fff, 16'h8000, 16'h8001, 16'h0001};
    for (int i = 0; i < 6; i++) begin
      op = alu_op_e'(i);
      fork
        begin
          send_req(op, CMP_NONE, 1'b0, edge1, '0, edge2, rand_vec());
          send_req(op, CMP_NONE, 1'b0, rand_vec(), '0, rand_vec(), rand_vec());
          send_req(op, CMP_NONE, 1'b0, rand_vec(), '0, rand_vec(), rand_vec());
          drive_idle();
        end
        collect_resps("alu_ops", 3);
      join
    end
    report_test("alu_ops", errs);
  endtask

  task automatic scalar_broadcast();
    int errs;
    errs = err_cnt;
    fork
      begin
        send_req(ALU_ADD, CMP_NONE, 1'b1, rand_vec(), elem_t'($random(seed)), rand_vec(),
                 rand_vec());
        send_req(ALU_SUB, CMP_NONE, 1'b1, rand_vec(), 16'sh8000, rand_vec(), rand_vec());
        send_req(ALU_MAX, CMP_NONE, 1'b1, rand_vec(), -16'sd1, rand_vec(), rand_vec());
        send_req(ALU_MIN, CMP_LT, 1'b1, rand_vec(), 16'sd0, rand_vec(), rand_vec());
        drive_idle();
      end
      collect_resps("scalar_broadcast", 4);
    join
    report_test("scalar_broadcast", errs);
  endtask

  task automatic masked_merge();
    int   errs;
    vec_t a;
    vec_t b;
    vec_t same;
    errs = err_cnt;
    a    = {16'sd100, 16'sd7, -16'sd3, 16'sd5};
    b    = {16'sd100, -16'sd8, 16'sd4, 16'sd5};
    same = rand_vec();
    fork
      begin
        send_req(ALU_ADD, CMP_EQ, 1'b0, a, '0, b, rand_vec());
        send_req(ALU_SUB, CMP_NE, 1'b0, a, '0, b, rand_vec());
        send_req(ALU_XOR, CMP_LT, 1'b0, a, '0, b, rand_vec());
        send_req(ALU_MAX, CMP_LT, 1'b0, b, '0, a, rand_vec());
        send_req(ALU_MIN, CMP_EQ, 1'b0, same, '0, same, rand_vec());
        // Nothing active so the old destination comes back whole
        send_req(ALU_AND, CMP_NE, 1'b0, same, '0, same, rand_vec());
        drive_idle();
      end
      collect_resps("masked_merge", 6);
    join
    report_test("masked_merge", errs);
  endtask

  task automatic back_to_back();
    int      errs;
    alu_op_e op;
    cmp_op_e cmp;
    logic    sen;
    errs = err_cnt;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          op  = alu_op_e'(($random(seed) & 32'h7fff) % 6);
          cmp = cmp_op_e'($random(seed) & 3);
          sen = ($random(seed) & 1) != 0;
          send_req(op, cmp, sen, rand_vec(), elem_t'($random(seed)), rand_vec(), rand_vec());
        end
        drive_idle();
      end
      collect_resps("back_to_back", 8);
    join
    report_test("back_to_back", errs);
  endtask

  initial begin
    rst           = 1'b1;
    req_valid     = 1'b0;
    req_op        = ALU_ADD;
    req_cmp       = CMP_NONE;
    req_scalar_en = 1'b0;
    req_vs1       = '0;
    req_scalar    = '0;
    req_vs2       = '0;
    req_vd_old    = '0;
    reset_behavior();
    alu_ops();
    scalar_broadcast();
    masked_merge();
    back_to_back();
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule : vu_tb

/* verification/vu_chk.sv */
// Assertions on response timing and count range, bound into the vector slice top level
module vu_chk import vu_pkg::*; (
  input logic  clk_i,
  input logic  rst_i,
  input logic  req_valid_i,
  input logic  resp_valid_i,
  input popc_t resp_popc_i
);
  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////
  // Latency
  ////////////////////

  // Every request comes back three cycles later
  a_resp_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $past(req_valid_i, 3) |-> resp_valid_i)
    else $error("response missing three cycles after a request");

  // And no response appears on its own
  a_no_stray_resp: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_i |-> $past(req_valid_i, 3))
    else $error("response without a request three cycles before");

  ////////////////////
  // Reset and count
  ////////////////////

  a_quiet_in_reset: assert property (@(posedge clk_i)
    rst_i |=> !resp_valid_i)
    else $error("response valid while in reset");

  a_popc_range: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_i |-> (resp_popc_i <= popc_t'(NR_LANES)))
    else $error("active element count above lane count");

endmodule : vu_chk

bind vu_top vu_chk u_vu_chk (
  .clk_i       (clk_i       ),
  .rst_i       (rst_i       ),
  .req_valid_i (req_valid_i ),
  .resp_valid_i(resp_valid_o),
  .resp_popc_i (resp_popc_o )
);

/* design/vu_top.sv */
// Top level of the vector slice, wires the dispatcher, the lanes, the mask unit and the writeback

module vu_top import vu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  // Request strobe and operands
  input  logic    req_valid_i,
  input  alu_op_e req_op_i,
  input  cmp_op_e req_cmp_i,
  input  logic    req_scalar_en_i,
  input  vec_t    req_vs1_i,
  input  elem_t   req_scalar_i,
  input  vec_t    req_vs2_i,
  input  vec_t    req_vd_old_i,
  // Response three cycles after the request
  output logic    resp_valid_o,
  output vec_t    resp_vd_o,
  output mask_t   resp_mask_o,
  output popc_t   resp_popc_o
);

  ////////////////////
  // Dispatcher
  ////////////////////

  logic    iss_valid;
  alu_op_e iss_alu_op;
  cmp_op_e iss_cmp;
  vec_t    iss_vs1;
  vec_t    iss_vs2;
  vec_t    iss_vd_old;

  vu_dispatcher u_dispatcher (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .req_valid_i    (req_valid_i    ),
    .req_op_i       (req_op_i       ),
    .req_cmp_i      (req_cmp_i      ),
    .req_scalar_en_i(req_scalar_en_i),
    .req_vs1_i      (req_vs1_i      ),
    .req_scalar_i   (req_scalar_i   ),
    .req_vs2_i      (req_vs2_i      ),
    .req_vd_old_i   (req_vd_old_i   ),
    .iss_valid_o    (iss_valid      ),
    .iss_alu_op_o   (iss_alu_op     ),
    .iss_cmp_o      (iss_cmp        ),
    .iss_vs1_o      (iss_vs1        ),
    .iss_vs2_o      (iss_vs2        ),
    .iss_vd_old_o   (iss_vd_old     )
  );

  ////////////////////
  // Lanes
  ////////////////////

  logic [NR_LANES-1:0] lane_valid;
  vec_t                lane_res;

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vu_lane u_lane (
      .clk_i   (clk_i        ),
      .rst_i   (rst_i        ),
      .valid_i (iss_valid    ),
      .alu_op_i(iss_alu_op   ),
      .vs1_i   (iss_vs1[l]   ),
      .vs2_i   (iss_vs2[l]   ),
      .valid_o (lane_valid[l]),
      .res_o   (lane_res[l]  )
    );
  end : gen_lanes

  ////////////////////
  // Mask unit
  ////////////////////

  mask_t mask;

  // Its valid runs in step with the lanes, so lane 0 stands for both
  vu_masku u_masku (
    .clk_i  (clk_i    ),
    .rst_i  (rst_i    ),
    .valid_i(iss_valid),
    .cmp_i  (iss_cmp  ),
    .vs1_i  (iss_vs1  ),
    .vs2_i  (iss_vs2  ),
    .valid_o(         ),
    .mask_o (mask     )
  );

  // Lane 0 strobes the writeback while the other lanes and the mask unit run in step
  vu_writeback u_writeback (
    .clk_i       (clk_i        ),
    .rst_i       (rst_i        ),
    .iss_valid_i (iss_valid    ),
    .vd_old_i    (iss_vd_old   ),
    .lane_valid_i(lane_valid[0]),
    .lane_res_i  (lane_res     ),
    .mask_i      (mask         ),
    .resp_valid_o(resp_valid_o ),
    .resp_vd_o   (resp_vd_o    ),
    .resp_mask_o (resp_mask_o  ),
    .resp_popc_o (resp_popc_o  )
  );

endmodule : vu_top

/* design/vu_writeback.sv */
// Final stage, merges lane results into the old destination under the mask and counts active elements

module vu_writeback import vu_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  // Old destination arrives with the issue strobe
  input  logic  iss_valid_i,
  input  vec_t  vd_old_i,
  // Lane and mask results, all in step
  input  logic  lane_valid_i,
  input  vec_t  lane_res_i,
  input  mask_t mask_i,
  // Response
  output logic  resp_valid_o,
  output vec_t  resp_vd_o,
  output mask_t resp_mask_o,
  output popc_t resp_popc_o
);

  vec_t  vd_old_q;
  vec_t  vd_merge;
  popc_t popc_d;

  // Holds the old destination for the lane stage
  always_ff @(posedge clk_i) begin
    if (iss_valid_i) begin
      vd_old_q <= vd_old_i;
    end
  end

  // Inactive elements keep their old value
  always_comb begin
    popc_d = '0;
    for (int i = 0; i < NR_LANES; i++) begin
      vd_merge[i] = mask_i[i] ? lane_res_i[i] : vd_old_q[i];
      popc_d      = popc_d + popc_t'(mask_i[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= lane_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lane_valid_i) begin
      resp_vd_o   <= vd_merge;
      resp_mask_o <= mask_i;
      resp_popc_o <= popc_d;
    end
  end

endmodule : vu_writeback

/* design/vu_masku.sv */
// Mask unit, one compare bit per element over the full vector, registered in step with the lanes

module vu_masku import vu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    valid_i,
  input  cmp_op_e cmp_i,
  input  vec_t    vs1_i,
  input  vec_t    vs2_i,
  output logic    valid_o,
  output mask_t   mask_o
);

  mask_t mask_d;

  // Compare of vs2 against vs1 per element
  always_comb begin
    for (int i = 0; i < NR_LANES; i++) begin
      case (cmp_i)
        CMP_EQ:  mask_d[i] = (vs2_i[i] == vs1_i[i]);
        CMP_NE:  mask_d[i] = (vs2_i[i] != vs1_i[i]);
        // Signed less-than
        CMP_LT:  mask_d[i] = (vs2_i[i] < vs1_i[i]);
        default: mask_d[i] = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mask_o <= mask_d;
    end
  end

endmodule : vu_masku

/* design/vu_lane.sv */
// Registered integer ALU for a single element, one copy per lane in the top level

module vu_lane import vu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  input  logic    valid_i,
  input  alu_op_e alu_op_i,
  input  elem_t   vs1_i,
  input  elem_t   vs2_i,
  output logic    valid_o,
  output elem_t   res_o
);

  elem_t res_d;

  // Result is vs2 op vs1; add and sub wrap at ELEN bits
  always_comb begin
    case (alu_op_i)
      ALU_ADD: res_d = vs2_i + vs1_i;
      ALU_SUB: res_d = vs2_i - vs1_i;
      ALU_AND: res_d = vs2_i & vs1_i;
      ALU_XOR: res_d = vs2_i ^ vs1_i;
      // Signed compares, both operands are elem_t
      ALU_MIN: res_d = (vs2_i < vs1_i) ? vs2_i : vs1_i;
      ALU_MAX: res_d = (vs2_i > vs1_i) ? vs2_i : vs1_i;
      default: res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_o <= res_d;
    end
  end

endmodule : vu_lane

/* design/vu_dispatcher.sv */
// Request register stage, feeds decoded operands to the lanes, mask unit and writeback

module vu_dispatcher import vu_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  // Request from outside
  input  logic    req_valid_i,
  input  alu_op_e req_op_i,
  input  cmp_op_e req_cmp_i,
  input  logic    req_scalar_en_i,
  input  vec_t    req_vs1_i,
  input  elem_t   req_scalar_i,
  input  vec_t    req_vs2_i,
  input  vec_t    req_vd_old_i,
  // Issue to the execution units
  output logic    iss_valid_o,
  output alu_op_e iss_alu_op_o,
  output cmp_op_e iss_cmp_o,
  output vec_t    iss_vs1_o,
  output vec_t    iss_vs2_o,
  output vec_t    iss_vd_old_o
);

  vec_t vs1_sel;

  // Vector-scalar form, scalar copied into every element
  always_comb begin
    if (req_scalar_en_i) begin
      vs1_sel = {NR_LANES{req_scalar_i}};
    end else begin
      vs1_sel = req_vs1_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      iss_valid_o <= 1'b0;
    end else begin
      iss_valid_o <= req_valid_i;
    end
  end

  // Payload only moves with a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      iss_alu_op_o <= req_op_i;
      iss_cmp_o    <= req_cmp_i;
      iss_vs1_o    <= vs1_sel;
      iss_vs2_o    <= req_vs2_i;
      iss_vd_old_o <= req_vd_old_i;
    end
  end

endmodule : vu_dispatcher

/* design/vu_pkg.sv */
// Sizes, element types and operation encodings, imported by every block of the vector slice

package vu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // One element per lane
  localparam int unsigned NR_LANES = 4;
  localparam int unsigned ELEN     = 16;
  localparam int unsigned POPC_W   = $clog2(NR_LANES + 1);

  ////////////////////
  // Data types
  ////////////////////

  typedef logic signed [ELEN-1:0] elem_t;

  // Lane 0 sits in the low bits
  typedef elem_t [NR_LANES-1:0] vec_t;

  typedef logic [NR_LANES-1:0] mask_t;
  typedef logic [POPC_W-1:0]   popc_t;

  ////////////////////
  // Operations
  ////////////////////

  // Lane ALU ops, MIN and MAX are signed
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_MIN,
    ALU_MAX
  } alu_op_e;

  // Mask sources; NONE enables every element
  typedef enum logic [1:0] {
    CMP_NONE,
    CMP_EQ,
    CMP_NE,
    CMP_LT
  } cmp_op_e;

endpackage : vu_pkg
